//--- rtl/psg_defs.svh
// psg register map, register count and noise LFSR constants
`ifndef PSG_DEFS_SVH
`define PSG_DEFS_SVH

`define PSG_ADDR_TONE_A_FINE   4'd0  // channel A period, low byte
`define PSG_ADDR_TONE_A_COARSE 4'd1  // channel A period, high nibble
`define PSG_ADDR_TONE_B_FINE   4'd2
`define PSG_ADDR_TONE_B_COARSE 4'd3
`define PSG_ADDR_TONE_C_FINE   4'd4
`define PSG_ADDR_TONE_C_COARSE 4'd5
`define PSG_ADDR_NOISE         4'd6  // 5-bit noise period
`define PSG_ADDR_MIXER         4'd7  // enables, port directions
`define PSG_ADDR_AMP_A         4'd8
`define PSG_ADDR_AMP_B         4'd9
`define PSG_ADDR_AMP_C         4'd10
`define PSG_ADDR_ENV_FINE      4'd11
`define PSG_ADDR_ENV_COARSE    4'd12
`define PSG_ADDR_ENV_SHAPE     4'd13 // write restarts the envelope
`define PSG_ADDR_IOA           4'd14
`define PSG_ADDR_IOB           4'd15

`define PSG_NUM_REGS  16
`define PSG_LFSR_W    17
`define PSG_LFSR_SEED 17'h1 // any nonzero value avoids lockup

`endif

//--- rtl/psg_pkg.sv
// psg shared vector types and envelope FSM states
`default_nettype none

package psg_pkg;

    typedef logic [7:0]  data_t;         // bus byte
    typedef logic [3:0]  reg_addr_t;     // register index
    typedef logic [11:0] tone_period_t;  // tone divider period
    typedef logic [4:0]  noise_period_t; // noise divider period
    typedef logic [15:0] env_period_t;   // envelope divider period
    typedef logic [3:0]  level_t;        // amplitude step, 0..15
    typedef logic [4:0]  amp_t;          // bit 4 picks envelope
    typedef logic [7:0]  chan_out_t;     // linear channel level
    typedef logic [9:0]  mix_t;          // sum of three channels

    // envelope FSM
    typedef enum logic {
        ENV_RUN,  // stepping through a ramp
        ENV_HOLD  // frozen at final level
    } env_state_t;

endpackage

`default_nettype wire

//--- rtl/psg_tone.sv
// psg tone generator, divide-by-8 prescale and 12-bit period counter
`timescale 1ns/1ps
`default_nettype none

module psg_tone import psg_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          tick,    // chip clock pulse
    input  tone_period_t period,
    output logic         tone     // square wave
);

    logic [2:0]   pre;     // divide by 8
    tone_period_t cnt;     // steps since last toggle
    tone_period_t per_eff; // period 0 acts as 1

    assign per_eff = (period == 12'd0) ? 12'd1 : period;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre  <= 3'd0;
            cnt  <= 12'd0;
            tone <= 1'b0;
        end else if (tick) begin
            pre <= pre + 3'd1;
            if (pre == 3'd7) begin
                if (cnt + 12'd1 >= per_eff) begin // >= copes with a shrinking period
                    cnt  <= 12'd0;
                    tone <= ~tone;
                end else begin
                    cnt <= cnt + 12'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/psg_noise.sv
// psg noise generator, 5-bit period divider stepping a 17-bit LFSR
`timescale 1ns/1ps
`default_nettype none

`include "psg_defs.svh"

module psg_noise import psg_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           tick,
    input  noise_period_t period,
    output logic          noise
);

    logic [3:0]             pre;     // divide by 16
    noise_period_t          cnt;
    noise_period_t          per_eff;
    logic [`PSG_LFSR_W-1:0] lfsr;

    assign per_eff = (period == 5'd0) ? 5'd1 : period;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre  <= 4'd0;
            cnt  <= 5'd0;
            lfsr <= `PSG_LFSR_SEED;
        end else if (tick) begin
            pre <= pre + 4'd1;
            if (pre == 4'd15) begin
                if (cnt + 5'd1 >= per_eff) begin
                    cnt  <= 5'd0;
                    lfsr <= {lfsr[0] ^ lfsr[3], lfsr[`PSG_LFSR_W-1:1]}; // taps 0 and 3
                end else begin
                    cnt <= cnt + 5'd1;
                end
            end
        end
    end

    assign noise = lfsr[0];

endmodule

`default_nettype wire

//--- rtl/psg_env.sv
// psg envelope generator, period divider and 4-bit step FSM for the 16 shapes
`timescale 1ns/1ps
`default_nettype none

module psg_env import psg_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         tick,
    input  env_period_t period,
    input  level_t      shape,   // {continue, attack, alternate, hold}
    input  wire         restart, // shape register written
    output level_t      level
);

    logic [3:0]  pre;      // divide by 16
    env_period_t cnt;
    env_period_t per_eff;
    logic        step_en;  // one envelope step due
    level_t      step;     // position in ramp
    logic        up;       // ramp direction
    env_state_t  state;

    assign per_eff = (period == 16'd0) ? 16'd1 : period;
    assign step_en = tick && (pre == 4'd15) && (cnt + 16'd1 >= per_eff);

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            pre <= 4'd0;
            cnt <= 16'd0;
        end else if (tick) begin
            pre <= pre + 4'd1;
            if (pre == 4'd15) cnt <= step_en ? 16'd0 : cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step  <= 4'd15;
            up    <= 1'b0;     // level 0 until first shape write
            state <= ENV_HOLD;
        end else if (restart) begin
            step  <= 4'd0;
            up    <= shape[2]; // attack bit
            state <= ENV_RUN;
        end else if (step_en && state == ENV_RUN) begin
            if (step != 4'd15) begin
                step <= step + 4'd1;
            end else if (!shape[3]) begin // no continue, settle at 0
                up    <= 1'b0;
                state <= ENV_HOLD;
            end else if (shape[0]) begin  // hold, alternate flips final level
                up    <= up ^ shape[1];
                state <= ENV_HOLD;
            end else begin                // repeat, maybe reversed
                step <= 4'd0;
                up   <= up ^ shape[1];
            end
        end
    end

    assign level = up ? step : ~step; // falling ramps count inverted

endmodule

`default_nettype wire

//--- rtl/psg_mixer.sv
// psg mixer, tone/noise gating, amplitude select, log volume table and sum
`timescale 1ns/1ps
`default_nettype none

module psg_mixer import psg_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       tone_a,
    input  wire       tone_b,
    input  wire       tone_c,
    input  wire       noise,
    input  data_t     mix_ctrl,  // [2:0] tone off, [5:3] noise off
    input  amp_t      amp_a,
    input  amp_t      amp_b,
    input  amp_t      amp_c,
    input  level_t    env_level,
    output chan_out_t a,
    output chan_out_t b,
    output chan_out_t c,
    output mix_t      sound
);

    chan_out_t va, vb, vc; // next channel levels

    // gated step: fixed or envelope amplitude, 0 when muted
    function automatic level_t chan_step(input logic on, input amp_t amp, input level_t env);
        if (!on) chan_step = 4'd0;
        else if (amp[4]) chan_step = env;
        else chan_step = amp[3:0];
    endfunction

    // roughly 3 dB per step
    function automatic chan_out_t log_vol(input level_t s);
        case (s)
            4'd0:    log_vol = 8'd0;
            4'd1:    log_vol = 8'd2;
            4'd2:    log_vol = 8'd3;
            4'd3:    log_vol = 8'd4;
            4'd4:    log_vol = 8'd6;
            4'd5:    log_vol = 8'd8;
            4'd6:    log_vol = 8'd11;
            4'd7:    log_vol = 8'd16;
            4'd8:    log_vol = 8'd23;
            4'd9:    log_vol = 8'd32;
            4'd10:   log_vol = 8'd45;
            4'd11:   log_vol = 8'd64;
            4'd12:   log_vol = 8'd90;
            4'd13:   log_vol = 8'd128;
            4'd14:   log_vol = 8'd181;
            default: log_vol = 8'd255;
        endcase
    endfunction

    assign va = log_vol(chan_step((tone_a | mix_ctrl[0]) & (noise | mix_ctrl[3]), amp_a, env_level));
    assign vb = log_vol(chan_step((tone_b | mix_ctrl[1]) & (noise | mix_ctrl[4]), amp_b, env_level));
    assign vc = log_vol(chan_step((tone_c | mix_ctrl[2]) & (noise | mix_ctrl[5]), amp_c, env_level));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a     <= 8'd0;
            b     <= 8'd0;
            c     <= 8'd0;
            sound <= 10'd0;
        end else begin
            a     <= va;
            b     <= vb;
            c     <= vc;
            sound <= mix_t'(va) + mix_t'(vb) + mix_t'(vc); // max 765, fits 10 bits
        end
    end

endmodule

`default_nettype wire

//--- rtl/psg_regs.sv
// psg register file, masked storage, readback mux and I/O port direction
`timescale 1ns/1ps
`default_nettype none

`include "psg_defs.svh"

module psg_regs import psg_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  reg_addr_t     addr,
    input  wire           cs_n,
    input  wire           wr_n,
    input  data_t         din,
    output data_t         dout,        // zero unless a read is active
    input  data_t         ioa_in,
    input  data_t         iob_in,
    output data_t         ioa_out,
    output data_t         iob_out,
    output tone_period_t  tone_per_a,
    output tone_period_t  tone_per_b,
    output tone_period_t  tone_per_c,
    output noise_period_t noise_per,
    output data_t         mix_ctrl,
    output amp_t          amp_a,
    output amp_t          amp_b,
    output amp_t          amp_c,
    output env_period_t   env_per,
    output level_t        env_shape,
    output logic          env_restart  // one clk after a shape write
);

    data_t regs [`PSG_NUM_REGS];
    logic  wr_en;
    data_t rd_data;

    // implemented bits per register
    function automatic data_t reg_mask(input reg_addr_t ra);
        case (ra)
            `PSG_ADDR_TONE_A_COARSE,
            `PSG_ADDR_TONE_B_COARSE,
            `PSG_ADDR_TONE_C_COARSE,
            `PSG_ADDR_ENV_SHAPE:     reg_mask = 8'h0F;
            `PSG_ADDR_NOISE,
            `PSG_ADDR_AMP_A,
            `PSG_ADDR_AMP_B,
            `PSG_ADDR_AMP_C:         reg_mask = 8'h1F;
            default:                 reg_mask = 8'hFF;
        endcase
    endfunction

    assign wr_en = !cs_n && !wr_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PSG_NUM_REGS; i++) regs[i] <= 8'h00; // r7=0: all on, ports in
            env_restart <= 1'b0;
        end else begin
            env_restart <= wr_en && (addr == `PSG_ADDR_ENV_SHAPE);
            if (wr_en) regs[addr] <= din & reg_mask(addr); // rewrites while phase lasts
        end
    end

    always_comb begin
        case (addr)
            `PSG_ADDR_IOA: rd_data = regs[`PSG_ADDR_MIXER][6] ? regs[addr] : ioa_in;
            `PSG_ADDR_IOB: rd_data = regs[`PSG_ADDR_MIXER][7] ? regs[addr] : iob_in;
            default:       rd_data = regs[addr];
        endcase
    end

    assign dout = (!cs_n && wr_n) ? rd_data : 8'h00;

    // port pins float high when set as input
    assign ioa_out = regs[`PSG_ADDR_MIXER][6] ? regs[`PSG_ADDR_IOA] : 8'hFF;
    assign iob_out = regs[`PSG_ADDR_MIXER][7] ? regs[`PSG_ADDR_IOB] : 8'hFF;

    assign tone_per_a = {regs[`PSG_ADDR_TONE_A_COARSE][3:0], regs[`PSG_ADDR_TONE_A_FINE]};
    assign tone_per_b = {regs[`PSG_ADDR_TONE_B_COARSE][3:0], regs[`PSG_ADDR_TONE_B_FINE]};
    assign tone_per_c = {regs[`PSG_ADDR_TONE_C_COARSE][3:0], regs[`PSG_ADDR_TONE_C_FINE]};
    assign noise_per  = regs[`PSG_ADDR_NOISE][4:0];
    assign mix_ctrl   = regs[`PSG_ADDR_MIXER];
    assign amp_a      = regs[`PSG_ADDR_AMP_A][4:0];
    assign amp_b      = regs[`PSG_ADDR_AMP_B][4:0];
    assign amp_c      = regs[`PSG_ADDR_AMP_C][4:0];
    assign env_per    = {regs[`PSG_ADDR_ENV_COARSE], regs[`PSG_ADDR_ENV_FINE]};
    assign env_shape  = regs[`PSG_ADDR_ENV_SHAPE][3:0];

endmodule

`default_nettype wire

//--- rtl/psg_core.sv
// psg core, tick prescaler plus wiring of registers, generators and mixer
`timescale 1ns/1ps
`default_nettype none

module psg_core import psg_pkg::*; (
    input  wire       rst_n,
    input  wire       clk,
    input  wire       clk_en,
    input  wire       sel,     // high: every clk_en is a tick
    input  reg_addr_t addr,
    input  wire       cs_n,
    input  wire       wr_n,
    input  data_t     din,
    output data_t     dout,
    output mix_t      sound,
    output chan_out_t a,
    output chan_out_t b,
    output chan_out_t c,
    input  data_t     ioa_in,
    output data_t     ioa_out,
    input  data_t     iob_in,
    output data_t     iob_out
);

    logic          half;        // divide-by-2 phase
    logic          tick;        // chip clock pulse
    tone_period_t  tone_per_a, tone_per_b, tone_per_c;
    noise_period_t noise_per;
    data_t         mix_ctrl;
    amp_t          amp_a, amp_b, amp_c;
    env_period_t   env_per;
    level_t        env_shape;
    logic          env_restart;
    logic          tone_a, tone_b, tone_c;
    logic          noise;
    level_t        env_level;

    always_ff @(posedge clk) begin
        if (!rst_n) half <= 1'b0;
        else if (clk_en && !sel) half <= ~half; // only counts in div-2 mode
    end

    assign tick = clk_en && (sel || half); // every second clk_en when sel low

    psg_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .cs_n        (cs_n),
        .wr_n        (wr_n),
        .din         (din),
        .dout        (dout),
        .ioa_in      (ioa_in),
        .iob_in      (iob_in),
        .ioa_out     (ioa_out),
        .iob_out     (iob_out),
        .tone_per_a  (tone_per_a),
        .tone_per_b  (tone_per_b),
        .tone_per_c  (tone_per_c),
        .noise_per   (noise_per),
        .mix_ctrl    (mix_ctrl),
        .amp_a       (amp_a),
        .amp_b       (amp_b),
        .amp_c       (amp_c),
        .env_per     (env_per),
        .env_shape   (env_shape),
        .env_restart (env_restart)
    );

    psg_tone u_tone_a (.clk(clk), .rst_n(rst_n), .tick(tick), .period(tone_per_a), .tone(tone_a));
    psg_tone u_tone_b (.clk(clk), .rst_n(rst_n), .tick(tick), .period(tone_per_b), .tone(tone_b));
    psg_tone u_tone_c (.clk(clk), .rst_n(rst_n), .tick(tick), .period(tone_per_c), .tone(tone_c));

    psg_noise u_noise (.clk(clk), .rst_n(rst_n), .tick(tick), .period(noise_per), .noise(noise));

    psg_env u_env (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .period  (env_per),
        .shape   (env_shape),
        .restart (env_restart),
        .level   (env_level)
    );

    psg_mixer u_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .tone_a    (tone_a),
        .tone_b    (tone_b),
        .tone_c    (tone_c),
        .noise     (noise),
        .mix_ctrl  (mix_ctrl),
        .amp_a     (amp_a),
        .amp_b     (amp_b),
        .amp_c     (amp_c),
        .env_level (env_level),
        .a         (a),
        .b         (b),
        .c         (c),
        .sound     (sound)
    );

endmodule

`default_nettype wire

//--- rtl/psg_bus.sv
// psg top level, BDIR/BC1 decode into latch, write and read strobes for the core
`timescale 1ns/1ps
`default_nettype none

`include "psg_defs.svh"

module psg_bus import psg_pkg::*; (
    input  wire       rst_n,
    input  wire       clk,
    input  wire       clk_en,  // input clock tick
    input  wire       bdir,    // bus direction pin
    input  wire       bc1,     // bus control pin
    input  data_t     din,     // kept apart from dout
    input  wire       sel,     // low divides clk_en by two
    output data_t     dout,
    output mix_t      sound,   // a + b + c
    output chan_out_t a,
    output chan_out_t b,
    output chan_out_t c,
    input  data_t     ioa_in,
    output data_t     ioa_out,
    input  data_t     iob_in,
    output data_t     iob_out
);

    logic      wr_n;      // registered write strobe
    logic      cs_n;      // registered chip select
    reg_addr_t addr;      // latched register index
    logic      addr_ok;   // upper nibble was zero
    data_t     din_latch; // latched write data

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_n    <= 1'b1;
            cs_n    <= 1'b1;
            addr    <= `PSG_ADDR_TONE_A_FINE;
            addr_ok <= 1'b1;
        end else begin
            case ({bdir, bc1})
                2'b00: {wr_n, cs_n} <= 2'b11; // inactive
                2'b01: {wr_n, cs_n} <= addr_ok ? 2'b10 : 2'b11; // read
                2'b10: begin // level-sensitive write
                    {wr_n, cs_n} <= addr_ok ? 2'b00 : 2'b11;
                    din_latch    <= din;
                end
                2'b11: begin // address latch
                    {wr_n, cs_n} <= 2'b11;
                    addr         <= din[3:0];
                    addr_ok      <= (din[7:4] == 4'd0); // reject foreign chip addrs
                end
                default: {wr_n, cs_n} <= 2'b11;
            endcase
        end
    end

    psg_core u_core (
        .rst_n   (rst_n),
        .clk     (clk),
        .clk_en  (clk_en),
        .sel     (sel),
        .addr    (addr),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .din     (din_latch),
        .dout    (dout),
        .sound   (sound),
        .a       (a),
        .b       (b),
        .c       (c),
        .ioa_in  (ioa_in),
        .ioa_out (ioa_out),
        .iob_in  (iob_in),
        .iob_out (iob_out)
    );

endmodule

`default_nettype wire

//--- tb/psg_tb.sv
// psg testbench, drives the BDIR/BC1 bus through register, port, mixer, tone and envelope checks
`timescale 1ns/1ps
`default_nettype none

`include "psg_defs.svh"

module psg_tb import psg_pkg::*; ();

    localparam int TBL_LEN    = `PSG_NUM_REGS;
    localparam int ACCESS_CYC = 10;                       // latch plus write or read with idle slots
    localparam int TONE_WAIT  = 4 * 64;                   // sync plus measured toggles
    localparam int ENV_WAIT   = 400 + 2 * (16 * 16 + 64); // settle then fall then rise
    localparam int MAX_CYC    = 16 + (2 * TBL_LEN + 40) * ACCESS_CYC + TONE_WAIT + ENV_WAIT;

    logic      clk;
    logic      rst_n;
    logic      clk_en;
    logic      sel;
    logic      bdir;
    logic      bc1;
    data_t     din;
    data_t     dout;
    mix_t      sound;
    chan_out_t a, b, c;
    data_t     ioa_in, ioa_out, iob_in, iob_out;

    int        seed = 66;
    int        cycle_cnt = 0;
    reg_addr_t tbl_addr [TBL_LEN];
    data_t     tbl_data [TBL_LEN];  // random write bytes
    data_t     tbl_exp  [TBL_LEN];  // expected readback
    data_t     tbl_mask [TBL_LEN] = '{8'hFF, 8'h0F, 8'hFF, 8'h0F, 8'hFF, 8'h0F, 8'h1F, 8'hFF,
                                      8'h1F, 8'h1F, 8'h1F, 8'hFF, 8'hFF, 8'h0F, 8'hFF, 8'hFF};
    chan_out_t vol_tbl  [16]      = '{8'd0, 8'd2, 8'd3, 8'd4, 8'd6, 8'd8, 8'd11, 8'd16,
                                      8'd23, 8'd32, 8'd45, 8'd64, 8'd90, 8'd128, 8'd181, 8'd255};

    psg_bus i_dut (
        .rst_n   (rst_n),
        .clk     (clk),
        .clk_en  (clk_en),
        .bdir    (bdir),
        .bc1     (bc1),
        .din     (din),
        .sel     (sel),
        .dout    (dout),
        .sound   (sound),
        .a       (a),
        .b       (b),
        .c       (c),
        .ioa_in  (ioa_in),
        .ioa_out (ioa_out),
        .iob_in  (iob_in),
        .iob_out (iob_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYC) begin
            $display("timeout: test sequence ran past %0d cycles", MAX_CYC);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            stop_run();
        end
    endtask

    task automatic fill_table();
        for (int i = 0; i < TBL_LEN; i++) begin
            tbl_addr[i] = reg_addr_t'(i);
            tbl_data[i] = $random(seed);
            if (i == `PSG_ADDR_MIXER) tbl_data[i] = tbl_data[i] | 8'hC0; // both ports out
            tbl_exp[i] = tbl_data[i] & tbl_mask[i];
        end
    endtask

    // one bus phase then back to inactive
    task automatic bus_cycle(input logic bd, input logic b1, input data_t d);
        @(posedge clk);
        bdir <= bd;
        bc1  <= b1;
        din  <= d;
        @(posedge clk);
        bdir <= 1'b0;
        bc1  <= 1'b0;
    endtask

    task automatic bus_read(output data_t d);
        @(posedge clk);
        bdir <= 1'b0;
        bc1  <= 1'b1;
        @(posedge clk); // strobes registered here
        @(negedge clk);
        d = dout;       // stable mid-cycle
        @(posedge clk);
        bc1 <= 1'b0;
    endtask

    task automatic reg_write(input reg_addr_t ra, input data_t d);
        bus_cycle(1'b1, 1'b1, {4'h0, ra}); // address latch
        bus_cycle(1'b1, 1'b0, d);          // write phase
    endtask

    task automatic reg_read(input reg_addr_t ra, output data_t d);
        bus_cycle(1'b1, 1'b1, {4'h0, ra});
        bus_read(d);
    endtask

    // call at a falling edge; n counts falling edges up to the change
    task automatic wait_change(input int limit, output int n);
        chan_out_t prev;
        prev = a;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("channel a did not change within %0d cycles", limit);
                stop_run();
            end
        end while (a == prev);
    endtask

    task automatic wait_steady(input chan_out_t value, input int run, input int limit);
        int same;
        int n;
        same = 0;
        n = 0;
        while (same < run) begin
            @(negedge clk);
            n++;
            same = (a == value) ? same + 1 : 0;
            if (n > limit) begin
                $display("channel a never settled at %0d within %0d cycles", value, limit);
                stop_run();
            end
        end
    endtask

    task automatic hold_check(input chan_out_t value, input int n);
        repeat (n) begin
            @(negedge clk);
            check_val("a", a, value);
        end
    endtask

    initial begin
        int        gap;
        data_t     rd;
        chan_out_t a_last;
        rst_n  = 1'b0;
        clk_en = 1'b1;  // every clk is an input tick
        sel    = 1'b1;  // no divide by two
        bdir   = 1'b0;
        bc1    = 1'b0;
        din    = 8'h00;
        ioa_in = 8'h5A;
        iob_in = 8'hC3;
        fill_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < TBL_LEN; i++) begin // masked readback
            reg_write(tbl_addr[i], tbl_data[i]);
            reg_read(tbl_addr[i], rd);
            check_val($sformatf("dout[r%0d]", i), rd, tbl_exp[i]);
        end

        bus_cycle(1'b1, 1'b1, {4'h9, `PSG_ADDR_AMP_A}); // foreign chip address
        bus_cycle(1'b1, 1'b0, ~tbl_data[`PSG_ADDR_AMP_A]);
        bus_read(rd);
        check_val("dout", rd, 8'h00);                   // no select so bus reads 0
        reg_read(`PSG_ADDR_AMP_A, rd);
        check_val("dout", rd, tbl_exp[`PSG_ADDR_AMP_A]); // untouched

        @(negedge clk);
        check_val("ioa_out", ioa_out, tbl_data[`PSG_ADDR_IOA]);
        check_val("iob_out", iob_out, tbl_data[`PSG_ADDR_IOB]);
        reg_write(`PSG_ADDR_MIXER, 8'h3F); // tones and noise off with ports in
        reg_read(`PSG_ADDR_IOA, rd);
        check_val("dout", rd, ioa_in);
        reg_read(`PSG_ADDR_IOB, rd);
        check_val("dout", rd, iob_in);
        @(negedge clk);
        check_val("ioa_out", ioa_out, 8'hFF);
        check_val("iob_out", iob_out, 8'hFF);

        reg_write(`PSG_ADDR_AMP_A, 8'd15);
        reg_write(`PSG_ADDR_AMP_B, 8'd9);
        reg_write(`PSG_ADDR_AMP_C, 8'd4);
        repeat (2) @(posedge clk); // write lands, then mixer register
        @(negedge clk);
        check_val("a", a, 8'd255);
        check_val("b", b, 8'd32);
        check_val("c", c, 8'd6);
        check_val("sound", sound, 10'd293);

        reg_write(`PSG_ADDR_TONE_A_FINE, 8'd3);
        reg_write(`PSG_ADDR_TONE_A_COARSE, 8'd0);
        reg_write(`PSG_ADDR_MIXER, 8'h3E); // tone A only
        @(negedge clk);
        wait_change(64, gap);              // mixer write or a toggle
        wait_change(64, gap);              // first toggle at period 3
        a_last = a;
        for (int k = 0; k < 2; k++) begin
            wait_change(64, gap);
            check_val("a toggle spacing", gap, 24); // 8 * 3 ticks
            check_val("a", a, (a_last == 8'd0) ? vol_tbl[15] : 8'd0);
            a_last = a;
        end

        reg_write(`PSG_ADDR_ENV_FINE, 8'd1);
        reg_write(`PSG_ADDR_ENV_COARSE, 8'd0);
        reg_write(`PSG_ADDR_MIXER, 8'h3F);   // channel gate always open
        reg_write(`PSG_ADDR_AMP_A, 8'h10);   // envelope drives a
        reg_write(`PSG_ADDR_ENV_SHAPE, 8'd0);
        wait_steady(8'd0, 32, 400);          // decayed and holding
        reg_write(`PSG_ADDR_ENV_SHAPE, 8'd0); // restart the fall
        @(negedge clk);
        wait_change(8, gap);
        check_val("a", a, vol_tbl[15]);
        for (int s = 14; s >= 0; s--) begin
            wait_change(40, gap);
            check_val("a", a, vol_tbl[s]);
        end
        hold_check(8'd0, 32);

        reg_write(`PSG_ADDR_ENV_SHAPE, 8'd13); // attack then hold high
        @(negedge clk);
        for (int s = 1; s < 16; s++) begin
            wait_change(40, gap);
            check_val("a", a, vol_tbl[s]);
        end
        hold_check(vol_tbl[15], 32);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/psg_pkg.sv
rtl/psg_tone.sv
rtl/psg_noise.sv
rtl/psg_env.sv
rtl/psg_mixer.sv
rtl/psg_regs.sv
rtl/psg_core.sv
rtl/psg_bus.sv
tb/psg_tb.sv

//--- Bender.yml
package:
  name: psg

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/psg_pkg.sv
      - rtl/psg_tone.sv
      - rtl/psg_noise.sv
      - rtl/psg_env.sv
      - rtl/psg_mixer.sv
      - rtl/psg_regs.sv
      - rtl/psg_core.sv
      - rtl/psg_bus.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/psg_tb.sv
